// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int unsigned DATA_W    = 32;
  localparam int unsigned NUM_FLAGS = 6;

  // Bit positions in every 6-bit flag vector
  localparam int unsigned FLAG_CF = 0;
  localparam int unsigned FLAG_PF = 1;
  localparam int unsigned FLAG_AF = 2;
  localparam int unsigned FLAG_ZF = 3;
  localparam int unsigned FLAG_SF = 4;
  localparam int unsigned FLAG_OF = 5;

  // DF position inside a full eflags image
  localparam int unsigned EFLAGS_DF_BIT = 10;

  // Top bit of the operand per size
  localparam int unsigned MSB_8  = 7;
  localparam int unsigned MSB_16 = 15;
  localparam int unsigned MSB_32 = 31;

  // Decimal adjust limits and corrections
  localparam logic [3:0] BCD_DIGIT_MAX = 4'h9;
  localparam logic [7:0] BCD_BYTE_MAX  = 8'h99;
  localparam logic [7:0] DAA_LO_ADJ    = 8'h06;
  localparam logic [7:0] DAA_HI_ADJ    = 8'h60;

  // Group in bits [3:2] and unit in bits [1:0]
  // Codes 13 to 15 also decode as DAA
  typedef enum logic [3:0] {
    OP_OR       = 4'd0,
    OP_AND      = 4'd1,
    OP_SAL      = 4'd2,
    OP_SAR      = 4'd3,
    OP_PASS_SR1 = 4'd4,
    OP_PASS_SR2 = 4'd5,
    OP_ZERO     = 4'd6,
    OP_NOT      = 4'd7,
    OP_INC      = 4'd8,
    OP_ADD      = 4'd9,
    OP_PTR_STEP = 4'd10,
    OP_CMP_EAX  = 4'd11,
    OP_DAA      = 4'd12
  } alu1_op_e;

  // SZ64 only matters as an 8-byte pointer step
  typedef enum logic [1:0] {
    SZ8  = 2'd0,
    SZ16 = 2'd1,
    SZ32 = 2'd2,
    SZ64 = 2'd3
  } op_size_e;

endpackage

`default_nettype wire

// ==== flag_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_adder (
  input  logic [alu_pkg::DATA_W-1:0]    a,
  input  logic [alu_pkg::DATA_W-1:0]    b,
  input  logic                          cin,
  input  alu_pkg::op_size_e             size,
  output logic [alu_pkg::DATA_W-1:0]    sum,
  output logic [alu_pkg::NUM_FLAGS-1:0] flags
);

  logic [alu_pkg::DATA_W:0] full;
  // Carry into each bit with the final carry out on top
  logic [alu_pkg::DATA_W:0] carry;

  assign full  = {1'b0, a} + {1'b0, b} + {{alu_pkg::DATA_W{1'b0}}, cin};
  assign sum   = full[alu_pkg::DATA_W-1:0];
  assign carry = {full[alu_pkg::DATA_W], a ^ b ^ sum};

  always_comb begin
    flags = '0;
    flags[alu_pkg::FLAG_AF] = carry[4];
    flags[alu_pkg::FLAG_PF] = ~^sum[7:0];
    case (size)
      alu_pkg::SZ8: begin
        flags[alu_pkg::FLAG_CF] = carry[alu_pkg::MSB_8+1];
        flags[alu_pkg::FLAG_OF] = carry[alu_pkg::MSB_8+1] ^ carry[alu_pkg::MSB_8];
        flags[alu_pkg::FLAG_ZF] = (sum[alu_pkg::MSB_8:0] == '0);
        flags[alu_pkg::FLAG_SF] = sum[alu_pkg::MSB_8];
      end
      alu_pkg::SZ16: begin
        flags[alu_pkg::FLAG_CF] = carry[alu_pkg::MSB_16+1];
        flags[alu_pkg::FLAG_OF] = carry[alu_pkg::MSB_16+1] ^ carry[alu_pkg::MSB_16];
        flags[alu_pkg::FLAG_ZF] = (sum[alu_pkg::MSB_16:0] == '0);
        flags[alu_pkg::FLAG_SF] = sum[alu_pkg::MSB_16];
      end
      // SZ64 arithmetic is done at 32 bits
      default: begin
        flags[alu_pkg::FLAG_CF] = carry[alu_pkg::MSB_32+1];
        flags[alu_pkg::FLAG_OF] = carry[alu_pkg::MSB_32+1] ^ carry[alu_pkg::MSB_32];
        flags[alu_pkg::FLAG_ZF] = (sum[alu_pkg::MSB_32:0] == '0);
        flags[alu_pkg::FLAG_SF] = sum[alu_pkg::MSB_32];
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== shift_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_unit (
  input  logic [alu_pkg::DATA_W-1:0]    sr1,
  input  logic [4:0]                    amt,
  input  logic                          right,
  input  alu_pkg::op_size_e             size,
  output logic [alu_pkg::DATA_W-1:0]    res,
  output logic [alu_pkg::NUM_FLAGS-1:0] flags,
  output logic                          count_zero
);

  // One extra bit on each side catches the last bit shifted out
  logic [alu_pkg::DATA_W:0]        sal_ext;
  logic signed [alu_pkg::DATA_W:0] sar_ext;
  logic                            sal_cf;

  assign sal_ext    = {1'b0, sr1} << amt;
  assign sar_ext    = $signed({sr1, 1'b0}) >>> amt;
  assign count_zero = (amt == '0);

  always_comb begin
    res    = right ? sar_ext[alu_pkg::DATA_W:1] : sal_ext[alu_pkg::DATA_W-1:0];
    flags  = '0;
    sal_cf = 1'b0;
    flags[alu_pkg::FLAG_PF] = ~^res[7:0];
    case (size)
      alu_pkg::SZ8: begin
        // Bit (8 - amt) of sr1 or zero past the width
        sal_cf = sal_ext[alu_pkg::MSB_8+1];
        flags[alu_pkg::FLAG_ZF] = (res[alu_pkg::MSB_8:0] == '0);
        flags[alu_pkg::FLAG_SF] = res[alu_pkg::MSB_8];
      end
      alu_pkg::SZ16: begin
        sal_cf = sal_ext[alu_pkg::MSB_16+1];
        flags[alu_pkg::FLAG_ZF] = (res[alu_pkg::MSB_16:0] == '0);
        flags[alu_pkg::FLAG_SF] = res[alu_pkg::MSB_16];
      end
      default: begin
        sal_cf = sal_ext[alu_pkg::MSB_32+1];
        flags[alu_pkg::FLAG_ZF] = (res[alu_pkg::MSB_32:0] == '0);
        flags[alu_pkg::FLAG_SF] = res[alu_pkg::MSB_32];
      end
    endcase
    // SAR takes CF from bit (amt - 1) of sr1 and never sets OF
    flags[alu_pkg::FLAG_CF] = right ? sar_ext[0] : sal_cf;
    flags[alu_pkg::FLAG_OF] = right ? 1'b0 : (flags[alu_pkg::FLAG_SF] ^ sal_cf);
  end

endmodule

`default_nettype wire

// ==== daa_adjust.sv ====
`timescale 1ns/1ps
`default_nettype none

module daa_adjust (
  input  logic [alu_pkg::DATA_W-1:0]    eax,
  input  logic                          cf_in,
  input  logic                          af_in,
  output logic [alu_pkg::DATA_W-1:0]    res,
  output logic [alu_pkg::NUM_FLAGS-1:0] flags
);

  logic [7:0] al;
  logic [7:0] al_new;
  logic       lo_adj;
  logic       hi_adj;

  assign al = eax[7:0];

  // Both decisions look at AL before any correction
  assign lo_adj = (al[3:0] > alu_pkg::BCD_DIGIT_MAX) || af_in;
  assign hi_adj = (al > alu_pkg::BCD_BYTE_MAX) || cf_in;

  assign al_new = al
                + (lo_adj ? alu_pkg::DAA_LO_ADJ : 8'h00)
                + (hi_adj ? alu_pkg::DAA_HI_ADJ : 8'h00);

  assign res = {eax[alu_pkg::DATA_W-1:8], al_new};

  always_comb begin
    flags = '0;
    flags[alu_pkg::FLAG_CF] = hi_adj;
    flags[alu_pkg::FLAG_AF] = lo_adj;
    flags[alu_pkg::FLAG_PF] = ~^al_new;
    flags[alu_pkg::FLAG_ZF] = (al_new == 8'h00);
    flags[alu_pkg::FLAG_SF] = al_new[7];
  end

endmodule

`default_nettype wire

// ==== alu1.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu1 (
  input  logic [alu_pkg::DATA_W-1:0]    sr1,
  input  logic [alu_pkg::DATA_W-1:0]    sr2,
  input  logic [alu_pkg::DATA_W-1:0]    eax,
  input  logic [alu_pkg::DATA_W-1:0]    mem_out,
  input  logic [alu_pkg::DATA_W-1:0]    mem_out_latched,
  input  alu_pkg::alu1_op_e             alu1_op,
  input  alu_pkg::op_size_e             alu1_op_size,
  input  alu_pkg::op_size_e             mem_rd_size,
  input  logic                          cf_in,
  input  logic                          af_in,
  input  logic                          df_in,
  input  logic                          df_val,
  input  logic                          isr,
  input  logic [alu_pkg::NUM_FLAGS-1:0] ld_flags_in,
  output logic [alu_pkg::DATA_W-1:0]    alu_res1,
  output logic [alu_pkg::NUM_FLAGS-1:0] alu1_flags,
  output logic [alu_pkg::NUM_FLAGS-1:0] cmps_flags,
  output logic [alu_pkg::NUM_FLAGS-1:0] ld_flags_out,
  output logic                          df_val_ex
);

  logic [alu_pkg::DATA_W-1:0]    logic_res;
  logic [alu_pkg::NUM_FLAGS-1:0] logic_flags;
  logic [alu_pkg::DATA_W-1:0]    shift_res;
  logic [alu_pkg::NUM_FLAGS-1:0] shift_flags;
  logic                          count_zero;
  logic [alu_pkg::NUM_FLAGS-1:0] pass_flags;
  logic [alu_pkg::DATA_W-1:0]    inc_res;
  logic [alu_pkg::NUM_FLAGS-1:0] inc_flags;
  logic [alu_pkg::DATA_W-1:0]    add_res;
  logic [alu_pkg::NUM_FLAGS-1:0] add_flags;
  logic [alu_pkg::NUM_FLAGS-1:0] cmp_raw;
  logic [alu_pkg::NUM_FLAGS-1:0] cmps_raw;
  logic [alu_pkg::DATA_W-1:0]    ptr_step;
  logic [alu_pkg::DATA_W-1:0]    ptr_res;
  logic [alu_pkg::DATA_W-1:0]    daa_res;
  logic [alu_pkg::NUM_FLAGS-1:0] daa_flags;

  // OR and AND share one flag path that clears CF OF AF
  assign logic_res = (alu1_op == alu_pkg::OP_AND) ? (sr1 & sr2) : (sr1 | sr2);

  always_comb begin
    logic_flags = '0;
    logic_flags[alu_pkg::FLAG_PF] = ~^logic_res[7:0];
    case (alu1_op_size)
      alu_pkg::SZ8: begin
        logic_flags[alu_pkg::FLAG_ZF] = (logic_res[alu_pkg::MSB_8:0] == '0);
        logic_flags[alu_pkg::FLAG_SF] = logic_res[alu_pkg::MSB_8];
      end
      alu_pkg::SZ16: begin
        logic_flags[alu_pkg::FLAG_ZF] = (logic_res[alu_pkg::MSB_16:0] == '0);
        logic_flags[alu_pkg::FLAG_SF] = logic_res[alu_pkg::MSB_16];
      end
      default: begin
        logic_flags[alu_pkg::FLAG_ZF] = (logic_res[alu_pkg::MSB_32:0] == '0);
        logic_flags[alu_pkg::FLAG_SF] = logic_res[alu_pkg::MSB_32];
      end
    endcase
  end

  shift_unit u_shift (
    .sr1        (sr1),
    .amt        (sr2[4:0]),
    .right      (alu1_op == alu_pkg::OP_SAR),
    .size       (alu1_op_size),
    .res        (shift_res),
    .flags      (shift_flags),
    .count_zero (count_zero)
  );

  // Flags image popped from sr1 (the saved flags word)
  always_comb begin
    pass_flags = '0;
    pass_flags[alu_pkg::FLAG_CF] = sr1[0];
    pass_flags[alu_pkg::FLAG_PF] = sr1[2];
    pass_flags[alu_pkg::FLAG_AF] = sr1[4];
    pass_flags[alu_pkg::FLAG_ZF] = sr1[6];
    pass_flags[alu_pkg::FLAG_SF] = sr1[7];
    pass_flags[alu_pkg::FLAG_OF] = sr1[11];
  end

  flag_adder u_inc (
    .a     (sr1),
    .b     (32'd1),
    .cin   (1'b0),
    .size  (alu1_op_size),
    .sum   (inc_res),
    .flags (inc_flags)
  );

  flag_adder u_add (
    .a     (sr1),
    .b     (sr2),
    .cin   (1'b0),
    .size  (alu1_op_size),
    .sum   (add_res),
    .flags (add_flags)
  );

  // Only the flags of eax - sr1 are kept
  flag_adder u_cmp_eax (
    .a     (eax),
    .b     (~sr1),
    .cin   (1'b1),
    .size  (alu1_op_size),
    .sum   (),
    .flags (cmp_raw)
  );

  flag_adder u_cmps (
    .a     (mem_out_latched),
    .b     (~mem_out),
    .cin   (1'b1),
    .size  (mem_rd_size),
    .sum   (),
    .flags (cmps_raw)
  );

  // String pointer moves by the element size, backwards when DF is set
  assign ptr_step = 32'd1 << mem_rd_size;
  assign ptr_res  = df_in ? (sr1 - ptr_step) : (sr1 + ptr_step);

  daa_adjust u_daa (
    .eax   (eax),
    .cf_in (cf_in),
    .af_in (af_in),
    .res   (daa_res),
    .flags (daa_flags)
  );

  always_comb begin
    alu_res1   = daa_res;
    alu1_flags = '0;
    case (alu1_op)
      alu_pkg::OP_OR, alu_pkg::OP_AND: begin
        alu_res1   = logic_res;
        alu1_flags = logic_flags;
      end
      alu_pkg::OP_SAL, alu_pkg::OP_SAR: begin
        alu_res1   = shift_res;
        alu1_flags = shift_flags;
      end
      alu_pkg::OP_PASS_SR1: begin
        alu_res1   = sr1;
        alu1_flags = pass_flags;
      end
      alu_pkg::OP_PASS_SR2: alu_res1 = sr2;
      alu_pkg::OP_ZERO:     alu_res1 = '0;
      alu_pkg::OP_NOT:      alu_res1 = ~sr1;
      alu_pkg::OP_INC: begin
        alu_res1   = inc_res;
        alu1_flags = inc_flags;
      end
      alu_pkg::OP_ADD: begin
        alu_res1   = add_res;
        alu1_flags = add_flags;
      end
      alu_pkg::OP_PTR_STEP: alu_res1 = ptr_res;
      alu_pkg::OP_CMP_EAX: begin
        alu_res1   = sr1;
        alu1_flags = cmp_raw;
        alu1_flags[alu_pkg::FLAG_CF] = ~cmp_raw[alu_pkg::FLAG_CF];
      end
      default: begin
        alu_res1   = daa_res;
        alu1_flags = daa_flags;
      end
    endcase
  end

  // Carry out of a + ~b + 1 inverted to read as borrow
  always_comb begin
    cmps_flags = cmps_raw;
    cmps_flags[alu_pkg::FLAG_CF] = ~cmps_raw[alu_pkg::FLAG_CF];
  end

  assign df_val_ex = isr ? sr2[alu_pkg::EFLAGS_DF_BIT] : df_val;

  // Shift by zero leaves every flag alone
  assign ld_flags_out = ((alu1_op == alu_pkg::OP_SAL || alu1_op == alu_pkg::OP_SAR)
                         && count_zero) ? '0 : ld_flags_in;

endmodule

`default_nettype wire

// ==== eflags_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module eflags_reg (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr_en,
  input  logic [alu_pkg::NUM_FLAGS-1:0] alu_flags,
  input  logic [alu_pkg::NUM_FLAGS-1:0] ld_mask,
  input  logic                          ld_df,
  input  logic                          df_new,
  output logic [alu_pkg::NUM_FLAGS-1:0] flags,
  output logic                          df
);

  logic [alu_pkg::NUM_FLAGS-1:0] wr_mask;

  // Per-bit write enable
  assign wr_mask = wr_en ? ld_mask : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      flags <= (flags & ~wr_mask) | (alu_flags & wr_mask);
    end
  end

  // DF has its own load
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      df <= 1'b0;
    end else if (ld_df) begin
      df <= df_new;
    end
  end

endmodule

`default_nettype wire

// ==== exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  alu_pkg::alu1_op_e             alu1_op,
  input  alu_pkg::op_size_e             alu1_op_size,
  input  alu_pkg::op_size_e             mem_rd_size,
  input  logic [alu_pkg::DATA_W-1:0]    sr1,
  input  logic [alu_pkg::DATA_W-1:0]    sr2,
  input  logic [alu_pkg::DATA_W-1:0]    eax,
  input  logic [alu_pkg::DATA_W-1:0]    mem_out,
  input  logic [alu_pkg::DATA_W-1:0]    mem_out_latched,
  input  logic                          df_val,
  input  logic                          isr,
  input  logic [alu_pkg::NUM_FLAGS-1:0] ld_flags,
  input  logic                          ld_df,
  output logic                          res_valid,
  output logic [alu_pkg::DATA_W-1:0]    alu_res,
  output logic [alu_pkg::NUM_FLAGS-1:0] cmps_flags,
  output logic [alu_pkg::NUM_FLAGS-1:0] flags,
  output logic                          df
);

  logic [alu_pkg::DATA_W-1:0]    alu_res1;
  logic [alu_pkg::NUM_FLAGS-1:0] alu1_flags;
  logic [alu_pkg::NUM_FLAGS-1:0] cmps_flags_c;
  logic [alu_pkg::NUM_FLAGS-1:0] ld_flags_out;
  logic                          df_val_ex;

  alu1 u_alu1 (
    .sr1             (sr1),
    .sr2             (sr2),
    .eax             (eax),
    .mem_out         (mem_out),
    .mem_out_latched (mem_out_latched),
    .alu1_op         (alu1_op),
    .alu1_op_size    (alu1_op_size),
    .mem_rd_size     (mem_rd_size),
    .cf_in           (flags[alu_pkg::FLAG_CF]),
    .af_in           (flags[alu_pkg::FLAG_AF]),
    .df_in           (df),
    .df_val          (df_val),
    .isr             (isr),
    .ld_flags_in     (ld_flags),
    .alu_res1        (alu_res1),
    .alu1_flags      (alu1_flags),
    .cmps_flags      (cmps_flags_c),
    .ld_flags_out    (ld_flags_out),
    .df_val_ex       (df_val_ex)
  );

  // Flags land on the same edge as the result
  eflags_reg u_eflags (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (in_valid),
    .alu_flags (alu1_flags),
    .ld_mask   (ld_flags_out),
    .ld_df     (ld_df & in_valid),
    .df_new    (df_val_ex),
    .flags     (flags),
    .df        (df)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid  <= 1'b0;
      alu_res    <= '0;
      cmps_flags <= '0;
    end else begin
      res_valid <= in_valid;
      if (in_valid) begin
        alu_res    <= alu_res1;
        cmps_flags <= cmps_flags_c;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

  localparam int CLK_PERIOD = 8;
  localparam int RAND_COUNT = 200;

  typedef struct packed {
    alu_pkg::alu1_op_e op;
    alu_pkg::op_size_e size;
    alu_pkg::op_size_e mrs;
    logic [31:0]       sr1;
    logic [31:0]       sr2;
    logic [31:0]       eax;
    logic [31:0]       mo;
    logic [31:0]       mol;
    logic [5:0]        ld;
    logic              ld_df;
    logic              isr;
    logic              df_val;
    logic [31:0]       res;
    logic [5:0]        cmps;
    logic [5:0]        flags;
    logic              df;
  } vec_t;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  alu_pkg::alu1_op_e alu1_op;
  alu_pkg::op_size_e alu1_op_size;
  alu_pkg::op_size_e mem_rd_size;
  logic [31:0]       sr1;
  logic [31:0]       sr2;
  logic [31:0]       eax;
  logic [31:0]       mem_out;
  logic [31:0]       mem_out_latched;
  logic              df_val;
  logic              isr;
  logic [5:0]        ld_flags;
  logic              ld_df;
  logic              res_valid;
  logic [31:0]       alu_res;
  logic [5:0]        cmps_flags;
  logic [5:0]        flags;
  logic              df;

  vec_t        table_q[$];
  int          pass_cnt;
  int          fail_cnt;
  int          dir_count;
  logic        table_ready;
  logic [5:0]  model_flags;
  logic        model_df;
  logic [31:0] lcg_state;

  exec_stage u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .alu1_op         (alu1_op),
    .alu1_op_size    (alu1_op_size),
    .mem_rd_size     (mem_rd_size),
    .sr1             (sr1),
    .sr2             (sr2),
    .eax             (eax),
    .mem_out         (mem_out),
    .mem_out_latched (mem_out_latched),
    .df_val          (df_val),
    .isr             (isr),
    .ld_flags        (ld_flags),
    .ld_df           (ld_df),
    .res_valid       (res_valid),
    .alu_res         (alu_res),
    .cmps_flags      (cmps_flags),
    .flags           (flags),
    .df              (df)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    wait (table_ready === 1'b1);
    #((dir_count + RAND_COUNT + 20) * CLK_PERIOD * 4);
    $display("Timeout: the run did not reach its end in the expected time");
    $display("CHECKS FAILED");
    $finish;
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned width_of(input alu_pkg::op_size_e size);
    if (size == alu_pkg::SZ8) return 8;
    if (size == alu_pkg::SZ16) return 16;
    return 32;
  endfunction

  // ZF, SF and PF of a result at a given width
  function automatic logic [5:0] size_flags(input logic [31:0] r, input int unsigned w);
    logic [5:0] f;
    f = '0;
    f[alu_pkg::FLAG_ZF] = (w == 8) ? (r[7:0] == 0) : (w == 16) ? (r[15:0] == 0) : (r == 0);
    f[alu_pkg::FLAG_SF] = r[w-1];
    f[alu_pkg::FLAG_PF] = ~^r[7:0];
    return f;
  endfunction

  task automatic add_model(input logic [31:0] a, input logic [31:0] b, input logic cin,
                           input alu_pkg::op_size_e size,
                           output logic [31:0] sum, output logic [5:0] f);
    int unsigned w;
    logic [31:0] mask;
    logic [32:0] wide;
    logic [4:0]  nib;
    w    = width_of(size);
    mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 1);
    wide = {1'b0, a & mask} + {1'b0, b & mask} + cin;
    nib  = a[3:0] + b[3:0] + cin;
    sum  = a + b + cin;
    f    = size_flags(sum, w);
    f[alu_pkg::FLAG_CF] = wide[w];
    f[alu_pkg::FLAG_AF] = nib[4];
    f[alu_pkg::FLAG_OF] = (a[w-1] == b[w-1]) && (sum[w-1] != a[w-1]);
  endtask

  task automatic shift_model(input logic right, input logic [31:0] a, input logic [4:0] amt,
                             input alu_pkg::op_size_e size,
                             output logic [31:0] r, output logic [5:0] f);
    int unsigned w;
    logic        cf;
    w = width_of(size);
    if (right) begin
      r  = $signed(a) >>> amt;
      cf = (amt == 0) ? 1'b0 : a[amt-1];
    end else begin
      r  = a << amt;
      cf = (amt == 0 || amt > w) ? 1'b0 : a[w-amt];
    end
    f = size_flags(r, w);
    f[alu_pkg::FLAG_CF] = cf;
    f[alu_pkg::FLAG_OF] = right ? 1'b0 : (r[w-1] ^ cf);
  endtask

  task automatic push_vec(input alu_pkg::alu1_op_e op, input alu_pkg::op_size_e size,
                          input alu_pkg::op_size_e mrs,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] acc,
                          input logic [31:0] mo, input logic [31:0] mol,
                          input logic [5:0] ld, input logic ldd, input logic irq,
                          input logic dfv, input logic [31:0] res, input logic [5:0] cmps,
                          input logic [5:0] fl, input logic d);
    table_q.push_back('{op, size, mrs, a, b, acc, mo, mol, ld, ldd, irq, dfv,
                        res, cmps, fl, d});
  endtask

  // Expected flags and df are the whole register state after each entry
  task automatic load_directed();
    push_vec(alu_pkg::OP_OR, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0000_00f0, 32'h0000_000f, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_00ff, 6'h0e, 6'h02, 1'b0);
    push_vec(alu_pkg::OP_AND, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h1234_5680, 32'hffff_ff80, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h1234_5680, 6'h0e, 6'h10, 1'b0);
    push_vec(alu_pkg::OP_AND, alu_pkg::SZ16, alu_pkg::SZ8,
             32'h0001_0000, 32'h0001_ffff, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0001_0000, 6'h0e, 6'h0a, 1'b0);
    // Flags hold while masked out
    push_vec(alu_pkg::OP_NOT, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0f0f_0f0f, 32'h0, 32'h0, 32'h0, 32'h0,
             6'h00, 1'b0, 1'b0, 1'b0, 32'hf0f0_f0f0, 6'h0e, 6'h0a, 1'b0);
    push_vec(alu_pkg::OP_PASS_SR2, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0, 32'hdead_beef, 32'h0, 32'h0, 32'h0,
             6'h00, 1'b0, 1'b0, 1'b0, 32'hdead_beef, 6'h0e, 6'h0a, 1'b0);
    push_vec(alu_pkg::OP_ZERO, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h5555_aaaa, 32'h0, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0, 6'h0e, 6'h00, 1'b0);
    push_vec(alu_pkg::OP_INC, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0000_00ff, 32'h0, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0100, 6'h0e, 6'h0f, 1'b0);
    push_vec(alu_pkg::OP_INC, alu_pkg::SZ16, alu_pkg::SZ8,
             32'h0000_7fff, 32'h0, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_8000, 6'h0e, 6'h36, 1'b0);
    // Only CF loads
    push_vec(alu_pkg::OP_ADD, alu_pkg::SZ32, alu_pkg::SZ8,
             32'hffff_ffff, 32'h0000_0001, 32'h0, 32'h0, 32'h0,
             6'h01, 1'b0, 1'b0, 1'b0, 32'h0, 6'h0e, 6'h37, 1'b0);
    push_vec(alu_pkg::OP_ADD, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0000_0070, 32'h0000_0070, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_00e0, 6'h0e, 6'h30, 1'b0);
    push_vec(alu_pkg::OP_SAL, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0000_0081, 32'h0000_0001, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0102, 6'h0e, 6'h21, 1'b0);
    push_vec(alu_pkg::OP_SAR, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h8000_0010, 32'h0000_0005, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'hfc00_0000, 6'h0e, 6'h13, 1'b0);
    // Zero shift count keeps flags under a full mask
    push_vec(alu_pkg::OP_SAL, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0000_1234, 32'h0000_0020, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_1234, 6'h0e, 6'h13, 1'b0);
    push_vec(alu_pkg::OP_SAR, alu_pkg::SZ16, alu_pkg::SZ8,
             32'hffff_8000, 32'h0000_0004, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'hffff_f800, 6'h0e, 6'h12, 1'b0);
    // DAA sees AF from the BCD add 38 + 29
    push_vec(alu_pkg::OP_ADD, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0000_0038, 32'h0000_0029, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0061, 6'h0e, 6'h04, 1'b0);
    push_vec(alu_pkg::OP_DAA, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0, 32'h0, 32'habcd_ef61, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'habcd_ef67, 6'h0e, 6'h04, 1'b0);
    // BCD 99 + 99 carries out of both digits
    push_vec(alu_pkg::OP_ADD, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0000_0099, 32'h0000_0099, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0132, 6'h0e, 6'h25, 1'b0);
    push_vec(alu_pkg::OP_DAA, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0, 32'h0, 32'h0000_0032, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0098, 6'h0e, 6'h15, 1'b0);
    // eax against an equal, a greater and a lesser sr1
    push_vec(alu_pkg::OP_CMP_EAX, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0000_0005, 32'h0, 32'h0000_0005, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0005, 6'h0e, 6'h0e, 1'b0);
    push_vec(alu_pkg::OP_CMP_EAX, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0000_0005, 32'h0, 32'h0000_0003, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0005, 6'h0e, 6'h11, 1'b0);
    push_vec(alu_pkg::OP_CMP_EAX, alu_pkg::SZ8, alu_pkg::SZ8,
             32'h0000_0010, 32'h0, 32'h0000_0090, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0010, 6'h0e, 6'h14, 1'b0);
    // Pointer steps with CMPS alongside and df loaded from df_val or sr2
    push_vec(alu_pkg::OP_PTR_STEP, alu_pkg::SZ32, alu_pkg::SZ16,
             32'h0000_1000, 32'h0, 32'h0, 32'h0000_1235, 32'h0000_1234,
             6'h00, 1'b1, 1'b0, 1'b1, 32'h0000_1002, 6'h13, 6'h14, 1'b1);
    push_vec(alu_pkg::OP_PTR_STEP, alu_pkg::SZ32, alu_pkg::SZ32,
             32'h0000_1000, 32'h0, 32'h0, 32'hcafe_f00d, 32'hcafe_f00d,
             6'h00, 1'b1, 1'b1, 1'b1, 32'h0000_0ffc, 6'h0e, 6'h14, 1'b0);
    push_vec(alu_pkg::OP_PTR_STEP, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0000_1000, 32'h0000_0400, 32'h0, 32'h0000_007f, 32'h0000_0080,
             6'h00, 1'b1, 1'b1, 1'b0, 32'h0000_1001, 6'h20, 6'h14, 1'b1);
    push_vec(alu_pkg::OP_PTR_STEP, alu_pkg::SZ32, alu_pkg::SZ64,
             32'h0000_1000, 32'h0, 32'h0, 32'h0, 32'h0,
             6'h00, 1'b0, 1'b0, 1'b0, 32'h0000_0ff8, 6'h0e, 6'h14, 1'b1);
    push_vec(alu_pkg::OP_PASS_SR1, alu_pkg::SZ32, alu_pkg::SZ8,
             32'h0000_0801, 32'h0, 32'h0, 32'h0, 32'h0,
             6'h3f, 1'b0, 1'b0, 1'b0, 32'h0000_0801, 6'h0e, 6'h21, 1'b1);
  endtask

  task automatic add_random_vecs(input int count);
    logic [31:0]       r;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       acc;
    logic [31:0]       mo;
    logic [31:0]       mol;
    logic [31:0]       res;
    logic [31:0]       unused_sum;
    logic [5:0]        f;
    logic [5:0]        m;
    logic [5:0]        cmps;
    alu_pkg::alu1_op_e op;
    alu_pkg::op_size_e size;
    alu_pkg::op_size_e mrs;
    for (int k = 0; k < count; k++) begin
      r    = lcg_next();
      a    = lcg_next();
      b    = lcg_next();
      acc  = lcg_next();
      mo   = lcg_next();
      mol  = lcg_next();
      // Now and then make the compares come out equal
      if (r[15:13] == 3'd0) acc = a;
      if (r[12:10] == 3'd0) mol = mo;
      size = alu_pkg::op_size_e'(r[25:24]);
      mrs  = alu_pkg::op_size_e'(r[27:26]);
      m    = r[21:16];
      case (r[31:30])
        2'd0: begin
          op = alu_pkg::OP_ADD;
          add_model(a, b, 1'b0, size, res, f);
        end
        2'd1: begin
          op = alu_pkg::OP_CMP_EAX;
          add_model(acc, ~a, 1'b1, size, unused_sum, f);
          f[alu_pkg::FLAG_CF] = ~f[alu_pkg::FLAG_CF];
          res = a;
        end
        default: begin
          op = r[30] ? alu_pkg::OP_SAR : alu_pkg::OP_SAL;
          shift_model(r[30], a, b[4:0], size, res, f);
          if (b[4:0] == 5'd0) m = '0;
        end
      endcase
      add_model(mol, ~mo, 1'b1, mrs, unused_sum, cmps);
      cmps[alu_pkg::FLAG_CF] = ~cmps[alu_pkg::FLAG_CF];
      model_flags = (model_flags & ~m) | (f & m);
      push_vec(op, size, mrs, a, b, acc, mo, mol, r[21:16], 1'b0, 1'b0, 1'b0,
               res, cmps, model_flags, model_df);
    end
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic drive_vec(input vec_t v);
    in_valid        = 1'b1;
    alu1_op         = v.op;
    alu1_op_size    = v.size;
    mem_rd_size     = v.mrs;
    sr1             = v.sr1;
    sr2             = v.sr2;
    eax             = v.eax;
    mem_out         = v.mo;
    mem_out_latched = v.mol;
    ld_flags        = v.ld;
    ld_df           = v.ld_df;
    isr             = v.isr;
    df_val          = v.df_val;
  endtask

  task automatic check_vec(input vec_t v);
    if (res_valid !== 1'b1) begin
      $display("Result valid missing one cycle after an accepted operation at %0t", $time);
      fail_cnt++;
    end
    compare("alu_res", v.res, alu_res);
    compare("cmps_flags", v.cmps, cmps_flags);
    compare("flags", v.flags, flags);
    compare("df", v.df, df);
  endtask

  initial begin
    int n_dir;
    int start_fail;
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    alu1_op         = alu_pkg::OP_OR;
    alu1_op_size    = alu_pkg::SZ8;
    mem_rd_size     = alu_pkg::SZ8;
    sr1             = '0;
    sr2             = '0;
    eax             = '0;
    mem_out         = '0;
    mem_out_latched = '0;
    df_val          = 1'b0;
    isr             = 1'b0;
    ld_flags        = '0;
    ld_df           = 1'b0;
    pass_cnt        = 0;
    fail_cnt        = 0;
    table_ready     = 1'b0;
    lcg_state       = 32'h8ab3_39ac;

    load_directed();
    n_dir       = table_q.size();
    model_flags = table_q[n_dir-1].flags;
    model_df    = table_q[n_dir-1].df;
    add_random_vecs(RAND_COUNT);
    dir_count   = n_dir;
    table_ready = 1'b1;

    repeat (10) @(posedge clk);
    @(negedge clk);
    start_fail = fail_cnt;
    compare("flags", 32'h0, flags);
    compare("df", 32'h0, df);
    compare("res_valid", 32'h0, res_valid);
    compare("cmps_flags", 32'h0, cmps_flags);
    compare("alu_res", 32'h0, alu_res);
    $display("test reset: %s", (fail_cnt == start_fail) ? "ok" : "mismatch");
    start_fail = fail_cnt;
    rst_n = 1'b1;

    // Each result is checked as the next entry goes in
    for (int i = 0; i <= table_q.size(); i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_vec(table_q[i-1]);
        if (i <= n_dir) begin
          $display("test %0d %s: %s", i - 1, table_q[i-1].op.name(),
                   (fail_cnt == start_fail) ? "ok" : "mismatch");
          start_fail = fail_cnt;
        end
      end
      if (i < table_q.size()) begin
        drive_vec(table_q[i]);
      end else begin
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    compare("res_valid", 32'h0, res_valid);
    $display("test random: %0d back-to-back ops, %s", RAND_COUNT,
             (fail_cnt == start_fail) ? "ok" : "mismatch");

    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
alu_pkg.sv
flag_adder.sv
shift_unit.sv
daa_adjust.sv
alu1.sv
eflags_reg.sv
exec_stage.sv
tb_exec_stage.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - alu_pkg.sv
  - flag_adder.sv
  - shift_unit.sv
  - daa_adjust.sv
  - alu1.sv
  - eflags_reg.sv
  - exec_stage.sv
  - target: simulation
    files:
      - tb_exec_stage.sv
